/* source/ntm_macros.svh */
`ifndef NTM_MACROS_SVH
`define NTM_MACROS_SVH

// Q16.16 data word and its fraction point
`define NTM_WORD_BITS 32
`define NTM_FRAC_BITS 16

// Largest key length the buffer can hold
`define NTM_MAX_W 16
`define NTM_INDEX_BITS 16

// AXI4-Lite register byte offsets
`define NTM_REG_CTRL 8'h00
`define NTM_REG_STATUS 8'h04
`define NTM_REG_SIZE_N 8'h08
`define NTM_REG_SIZE_W 8'h0C
`define NTM_REG_BETA 8'h10
`define NTM_REG_BEST_INDEX 8'h14
`define NTM_REG_BEST_SCORE 8'h18

`endif

/* source/ntm_pkg.sv */
`include "ntm_macros.svh"

package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////

  // Signed Q16.16 word for k, M, beta and scores
  typedef logic signed [`NTM_WORD_BITS-1:0] word_t;

  // Full width sum of products
  typedef logic signed [2*`NTM_WORD_BITS-1:0] acc_t;

  // Row or column position
  typedef logic [`NTM_INDEX_BITS-1:0] index_t;

  //////////////////////////////////////////////////////////////////////
  // Sequencer states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    idle,
    load_key,
    load_memory,
    drain
  } engine_state_t;

endpackage

/* source/ntm_key_buffer.sv */
`timescale 1ns/1ps
`include "ntm_macros.svh"

module ntm_key_buffer import ntm_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   clear,
  input  logic   write_enable,
  input  word_t  write_data,
  input  index_t read_index,
  output word_t  read_data
);

  localparam int ADDR_BITS = $clog2(`NTM_MAX_W);

  // Key storage, one word per column
  word_t                key_mem [`NTM_MAX_W];
  logic [ADDR_BITS-1:0] write_ptr;

  // Pointer rewinds for every new key
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      write_ptr <= '0;
    end else if (clear) begin
      write_ptr <= '0;
    end else if (write_enable) begin
      write_ptr <= write_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_enable) begin
      key_mem[write_ptr] <= write_data;
    end
  end

  // Same key replayed for each memory row
  assign read_data = key_mem[read_index[ADDR_BITS-1:0]];

endmodule

/* source/ntm_dot_product.sv */
`timescale 1ns/1ps
`include "ntm_macros.svh"

module ntm_dot_product import ntm_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  element_valid,
  input  logic  first_element,
  input  logic  last_element,
  input  word_t key_word,
  input  word_t memory_word,
  input  word_t beta,
  output logic  score_valid,
  output word_t score
);

  acc_t  product;
  acc_t  sum_next;
  acc_t  sum_shift;
  acc_t  accumulator;
  word_t sim;
  logic  sim_valid;
  acc_t  scaled;
  acc_t  scaled_shift;

  //////////////////////////////////////////////////////////////////////
  // Stage one, multiply and accumulate
  //////////////////////////////////////////////////////////////////////

  // Sign extended operands give the exact 64-bit product
  assign product   = acc_t'(key_word) * acc_t'(memory_word);
  // First column starts a fresh sum
  assign sum_next  = (first_element ? acc_t'(0) : accumulator) + product;
  assign sum_shift = sum_next >>> `NTM_FRAC_BITS;

  always_ff @(posedge clk) begin
    if (element_valid) begin
      accumulator <= sum_next;
    end
    // Row finished, hand sim to the scaler
    if (element_valid && last_element) begin
      sim <= sum_shift[`NTM_WORD_BITS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sim_valid <= 1'b0;
    end else begin
      sim_valid <= element_valid & last_element;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage two, beta scaling
  //////////////////////////////////////////////////////////////////////

  assign scaled       = acc_t'(sim) * acc_t'(beta);
  assign scaled_shift = scaled >>> `NTM_FRAC_BITS;

  // Next row may already accumulate above while this one scales
  always_ff @(posedge clk) begin
    if (sim_valid) begin
      score <= scaled_shift[`NTM_WORD_BITS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      score_valid <= 1'b0;
    end else begin
      score_valid <= sim_valid;
    end
  end

endmodule

/* source/ntm_config_regs.sv */
`timescale 1ns/1ps
`include "ntm_macros.svh"

module ntm_config_regs import ntm_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // AXI4-Lite write channels
  input  logic        s_axi_awvalid,
  output logic        s_axi_awready,
  input  logic [7:0]  s_axi_awaddr,
  input  logic        s_axi_wvalid,
  output logic        s_axi_wready,
  input  logic [31:0] s_axi_wdata,
  input  logic [3:0]  s_axi_wstrb,
  output logic        s_axi_bvalid,
  output logic [1:0]  s_axi_bresp,
  input  logic        s_axi_bready,
  // AXI4-Lite read channels
  input  logic        s_axi_arvalid,
  output logic        s_axi_arready,
  input  logic [7:0]  s_axi_araddr,
  output logic        s_axi_rvalid,
  output logic [31:0] s_axi_rdata,
  output logic [1:0]  s_axi_rresp,
  input  logic        s_axi_rready,
  // Engine side
  input  logic        busy,
  input  logic        done,
  input  index_t      best_index,
  input  word_t       best_score,
  output logic        start,
  output index_t      size_n,
  output index_t      size_w,
  output word_t       beta
);

  logic        write_fire;
  logic        read_fire;
  logic        start_accept;
  logic        done_flag;
  logic [31:0] current_value;
  logic [31:0] write_value;
  logic [31:0] read_value;
  index_t      best_index_reg;
  word_t       best_score_reg;

  // Byte lanes with a strobe take the new data
  function automatic logic [31:0] merge_strobe(input logic [31:0] old_value,
                                               input logic [31:0] new_value,
                                               input logic [3:0]  strobe);
    logic [31:0] merged;
    merged = old_value;
    for (int b = 0; b < 4; b++) begin
      if (strobe[b]) begin
        merged[8*b +: 8] = new_value[8*b +: 8];
      end
    end
    return merged;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////////////

  // Address and data must arrive together, one response outstanding
  assign write_fire    = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
  assign s_axi_awready = write_fire;
  assign s_axi_wready  = write_fire;
  assign s_axi_bresp   = 2'b00;

  // Old contents of the target register for partial strobes
  always_comb begin
    case (s_axi_awaddr)
      `NTM_REG_SIZE_N: current_value = 32'(size_n);
      `NTM_REG_SIZE_W: current_value = 32'(size_w);
      `NTM_REG_BETA:   current_value = beta;
      default:         current_value = '0;
    endcase
  end

  assign write_value = merge_strobe(current_value, s_axi_wdata, s_axi_wstrb);

  // Start only from idle with both sizes set
  assign start_accept = write_fire && (s_axi_awaddr == `NTM_REG_CTRL) && write_value[0] &&
                        !busy && (size_n != '0) && (size_w != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_axi_bvalid   <= 1'b0;
      start          <= 1'b0;
      size_n         <= '0;
      size_w         <= index_t'(1);
      beta           <= '0;
      done_flag      <= 1'b0;
      best_index_reg <= '0;
      best_score_reg <= '0;
    end else begin
      start <= start_accept;
      // Response held until the master takes it
      if (write_fire) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
      if (write_fire) begin
        case (s_axi_awaddr)
          `NTM_REG_SIZE_N: size_n <= write_value[`NTM_INDEX_BITS-1:0];
          `NTM_REG_SIZE_W: begin
            // Out of range widths leave the old value
            if (write_value >= 32'd1 && write_value <= 32'(`NTM_MAX_W)) begin
              size_w <= write_value[`NTM_INDEX_BITS-1:0];
            end
          end
          `NTM_REG_BETA:   beta <= write_value;
          default:         ;
        endcase
      end
      // Sticky done until the next run begins
      if (start_accept) begin
        done_flag <= 1'b0;
      end else if (done) begin
        done_flag <= 1'b1;
      end
      if (done) begin
        best_index_reg <= best_index;
        best_score_reg <= best_score;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  assign s_axi_arready = ~s_axi_rvalid;
  assign read_fire     = s_axi_arvalid & s_axi_arready;
  assign s_axi_rresp   = 2'b00;

  always_comb begin
    case (s_axi_araddr)
      `NTM_REG_STATUS:     read_value = {30'b0, done_flag, busy};
      `NTM_REG_SIZE_N:     read_value = 32'(size_n);
      `NTM_REG_SIZE_W:     read_value = 32'(size_w);
      `NTM_REG_BETA:       read_value = beta;
      `NTM_REG_BEST_INDEX: read_value = 32'(best_index_reg);
      `NTM_REG_BEST_SCORE: read_value = best_score_reg;
      default:             read_value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_axi_rvalid <= 1'b0;
    end else if (read_fire) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // Read data captured with the address
  always_ff @(posedge clk) begin
    if (read_fire) begin
      s_axi_rdata <= read_value;
    end
  end

endmodule

/* source/ntm_content_addressing.sv */
`timescale 1ns/1ps

module ntm_content_addressing import ntm_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start,
  input  index_t size_n,
  input  index_t size_w,
  input  word_t  beta,
  input  logic   k_in_enable,
  input  word_t  k_in,
  input  logic   m_in_enable,
  input  word_t  m_in,
  output logic   k_out_enable,
  output logic   m_out_enable,
  output logic   c_out_enable,
  output word_t  c_out,
  output logic   busy,
  output logic   done,
  output index_t best_index,
  output word_t  best_score
);

  engine_state_t state;
  index_t        row_count;
  index_t        col_count;
  index_t        score_count;
  index_t        rows;
  index_t        cols;
  word_t         beta_run;
  word_t         key_word;
  word_t         score;
  logic          score_valid;
  logic          k_accept;
  logic          m_accept;
  logic          last_col;
  logic          last_row;
  logic          clear_key;

  //////////////////////////////////////////////////////////////////////
  // Stream handshakes
  //////////////////////////////////////////////////////////////////////

  assign k_out_enable = (state == load_key);
  assign m_out_enable = (state == load_memory);
  assign busy         = (state != idle);
  assign k_accept     = k_out_enable & k_in_enable;
  assign m_accept     = m_out_enable & m_in_enable;
  assign last_col     = (col_count == cols - index_t'(1));
  assign last_row     = (row_count == rows - index_t'(1));
  assign clear_key    = (state == idle) & start;

  // Sizes and beta frozen for the whole run
  always_ff @(posedge clk) begin
    if (clear_key) begin
      rows     <= size_n;
      cols     <= size_w;
      beta_run <= beta;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= idle;
      row_count   <= '0;
      col_count   <= '0;
      score_count <= '0;
      done        <= 1'b0;
      best_index  <= '0;
      best_score  <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state       <= load_key;
            row_count   <= '0;
            col_count   <= '0;
            score_count <= '0;
          end
        end
        load_key: begin
          if (k_accept) begin
            col_count <= last_col ? '0 : col_count + index_t'(1);
            if (last_col) state <= load_memory;
          end
        end
        load_memory: begin
          // Row major walk over M
          if (m_accept) begin
            col_count <= last_col ? '0 : col_count + index_t'(1);
            if (last_col && last_row) begin
              state <= drain;
            end else if (last_col) begin
              row_count <= row_count + index_t'(1);
            end
          end
        end
        drain: begin
          // Wait for the final score out of the pipeline
          if (score_valid && score_count == rows - index_t'(1)) begin
            state <= idle;
            done  <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
      // Strictly greater wins so ties keep the lower row
      if (score_valid) begin
        score_count <= score_count + index_t'(1);
        if (score_count == '0 || score > best_score) begin
          best_score <= score;
          best_index <= score_count;
        end
      end
    end
  end

  ntm_key_buffer key_buffer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear       (clear_key),
    .write_enable(k_accept),
    .write_data  (k_in),
    .read_index  (col_count),
    .read_data   (key_word)
  );

  ntm_dot_product dot_product_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .element_valid(m_accept),
    .first_element(col_count == '0),
    .last_element (last_col),
    .key_word     (key_word),
    .memory_word  (m_in),
    .beta         (beta_run),
    .score_valid  (score_valid),
    .score        (score)
  );

  assign c_out_enable = score_valid;
  assign c_out        = score;

endmodule

/* source/ntm_read_content_weighting.sv */
`timescale 1ns/1ps

module ntm_read_content_weighting import ntm_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // AXI4-Lite slave
  input  logic        s_axi_awvalid,
  output logic        s_axi_awready,
  input  logic [7:0]  s_axi_awaddr,
  input  logic        s_axi_wvalid,
  output logic        s_axi_wready,
  input  logic [31:0] s_axi_wdata,
  input  logic [3:0]  s_axi_wstrb,
  output logic        s_axi_bvalid,
  output logic [1:0]  s_axi_bresp,
  input  logic        s_axi_bready,
  input  logic        s_axi_arvalid,
  output logic        s_axi_arready,
  input  logic [7:0]  s_axi_araddr,
  output logic        s_axi_rvalid,
  output logic [31:0] s_axi_rdata,
  output logic [1:0]  s_axi_rresp,
  input  logic        s_axi_rready,
  // Key, memory and score streams
  input  logic        k_in_enable,
  input  word_t       k_in,
  output logic        k_out_enable,
  input  logic        m_in_enable,
  input  word_t       m_in,
  output logic        m_out_enable,
  output logic        c_out_enable,
  output word_t       c_out
);

  //////////////////////////////////////////////////////////////////////
  // Register block to engine
  //////////////////////////////////////////////////////////////////////

  logic   start;
  logic   busy;
  logic   done;
  index_t size_n;
  index_t size_w;
  word_t  beta;
  index_t best_index;
  word_t  best_score;

  ntm_config_regs config_regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wready (s_axi_wready),
    .s_axi_wdata  (s_axi_wdata),
    .s_axi_wstrb  (s_axi_wstrb),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bresp  (s_axi_bresp),
    .s_axi_bready (s_axi_bready),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rready (s_axi_rready),
    .busy         (busy),
    .done         (done),
    .best_index   (best_index),
    .best_score   (best_score),
    .start        (start),
    .size_n       (size_n),
    .size_w       (size_w),
    .beta         (beta)
  );

  // Content weighting engine
  ntm_content_addressing content_addressing_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .size_n      (size_n),
    .size_w      (size_w),
    .beta        (beta),
    .k_in_enable (k_in_enable),
    .k_in        (k_in),
    .m_in_enable (m_in_enable),
    .m_in        (m_in),
    .k_out_enable(k_out_enable),
    .m_out_enable(m_out_enable),
    .c_out_enable(c_out_enable),
    .c_out       (c_out),
    .busy        (busy),
    .done        (done),
    .best_index  (best_index),
    .best_score  (best_score)
  );

endmodule

/* bench/ntm_read_content_weighting_tb.sv */
`timescale 1ns/1ps
`include "ntm_macros.svh"

module ntm_read_content_weighting_tb import ntm_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int MAX_ROWS       = 8;

  logic        clk;
  logic        rst_n;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  logic [7:0]  s_axi_awaddr;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  logic [31:0] s_axi_wdata;
  logic [3:0]  s_axi_wstrb;
  logic        s_axi_bvalid;
  logic [1:0]  s_axi_bresp;
  logic        s_axi_bready;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  logic [7:0]  s_axi_araddr;
  logic        s_axi_rvalid;
  logic [31:0] s_axi_rdata;
  logic [1:0]  s_axi_rresp;
  logic        s_axi_rready;
  logic        k_in_enable;
  word_t       k_in;
  logic        k_out_enable;
  logic        m_in_enable;
  word_t       m_in;
  logic        m_out_enable;
  logic        c_out_enable;
  word_t       c_out;

  // Bookkeeping
  int          cycle = 0;
  int          pulse_count = 0;
  int          check_count;
  int          error_count;
  int          timeout_count;
  bit          aborted;
  bit          use_gaps;
  logic [31:0] lcg_state;

  // Stimulus and observed results
  word_t       key_vec [`NTM_MAX_W];
  word_t       mem_vec [MAX_ROWS*`NTM_MAX_W];
  word_t       score_seen [MAX_ROWS];
  int          score_cycle [MAX_ROWS];
  int          last_word_cycle [MAX_ROWS];

  ntm_read_content_weighting DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wready (s_axi_wready),
    .s_axi_wdata  (s_axi_wdata),
    .s_axi_wstrb  (s_axi_wstrb),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bresp  (s_axi_bresp),
    .s_axi_bready (s_axi_bready),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rready (s_axi_rready),
    .k_in_enable  (k_in_enable),
    .k_in         (k_in),
    .k_out_enable (k_out_enable),
    .m_in_enable  (m_in_enable),
    .m_in         (m_in),
    .m_out_enable (m_out_enable),
    .c_out_enable (c_out_enable),
    .c_out        (c_out)
  );

  always #5 clk = ~clk;

  // Cycle index of the current clock period
  always @(posedge clk) cycle <= cycle + 1;

  // Every score pulse, expected or not
  always @(negedge clk) begin
    if (c_out_enable) begin
      pulse_count <= pulse_count + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Later waits fall straight through once this is set
  task automatic report_timeout(input string what);
    error_count++;
    timeout_count++;
    aborted = 1'b1;
    $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
  endtask

  // Q16.16 reference: 64-bit dot product, shift, then beta scaling
  function automatic word_t model_score(input int row, input int w, input word_t b);
    logic signed [63:0] acc;
    logic signed [63:0] a;
    logic signed [63:0] m;
    logic signed [63:0] shifted;
    acc = 64'sd0;
    for (int i = 0; i < w; i++) begin
      a = key_vec[i];
      m = mem_vec[row*w + i];
      acc = acc + a * m;
    end
    shifted = acc >>> 16;
    a = word_t'(shifted[31:0]);
    m = b;
    shifted = (a * m) >>> 16;
    return shifted[31:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite master
  //////////////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    int tries;
    @(negedge clk);
    s_axi_awvalid = 1'b1;
    s_axi_awaddr  = addr;
    s_axi_wvalid  = 1'b1;
    s_axi_wdata   = data;
    s_axi_bready  = 1'b1;
    tries = 0;
    #1;
    while (!(s_axi_awready && s_axi_wready) && tries < TIMEOUT_CYCLES && !aborted) begin
      @(negedge clk);
      #1;
      tries++;
    end
    if (!(s_axi_awready && s_axi_wready) && !aborted) begin
      report_timeout("write address and data handshake");
    end
    // Transfer took place on the edge just passed
    @(negedge clk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    tries = 0;
    while (!s_axi_bvalid && tries < TIMEOUT_CYCLES && !aborted) begin
      @(negedge clk);
      tries++;
    end
    if (!s_axi_bvalid && !aborted) report_timeout("write response");
    check_value(32'(s_axi_bresp), 32'd0, "write response code");
    @(negedge clk);
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int tries;
    @(negedge clk);
    s_axi_arvalid = 1'b1;
    s_axi_araddr  = addr;
    tries = 0;
    #1;
    while (!s_axi_arready && tries < TIMEOUT_CYCLES && !aborted) begin
      @(negedge clk);
      #1;
      tries++;
    end
    if (!s_axi_arready && !aborted) report_timeout("read address handshake");
    @(negedge clk);
    s_axi_arvalid = 1'b0;
    tries = 0;
    while (!s_axi_rvalid && tries < TIMEOUT_CYCLES && !aborted) begin
      @(negedge clk);
      tries++;
    end
    if (!s_axi_rvalid && !aborted) report_timeout("read data");
    data = s_axi_rdata;
    check_value(32'(s_axi_rresp), 32'd0, "read response code");
    // Data is held until the ready is seen
    s_axi_rready = 1'b1;
    @(negedge clk);
    s_axi_rready = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] expected,
                            input string what);
    logic [31:0] value;
    axi_read(addr, value);
    check_value(value, expected, what);
  endtask

  task automatic configure(input int n, input int w, input word_t b);
    axi_write(`NTM_REG_SIZE_N, 32'(n));
    axi_write(`NTM_REG_SIZE_W, 32'(w));
    axi_write(`NTM_REG_BETA, b);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stream drivers and score monitor
  //////////////////////////////////////////////////////////////////////

  task automatic send_key(input int w);
    int          tries;
    logic [31:0] r;
    @(negedge clk);
    for (int i = 0; i < w; i++) begin
      if (use_gaps) begin
        r = lcg_next();
        repeat (r[31:30]) begin
          k_in_enable = 1'b0;
          @(negedge clk);
        end
      end
      k_in        = key_vec[i];
      k_in_enable = 1'b1;
      tries = 0;
      #1;
      while (!k_out_enable && tries < TIMEOUT_CYCLES && !aborted) begin
        @(negedge clk);
        #1;
        tries++;
      end
      if (!k_out_enable) begin
        if (!aborted) report_timeout("key request");
        k_in_enable = 1'b0;
        return;
      end
      @(negedge clk);
    end
    k_in_enable = 1'b0;
  endtask

  // Row major, starting right on the negedge where the key ended
  task automatic send_memory(input int n, input int w);
    int          tries;
    logic [31:0] r;
    for (int j = 0; j < n; j++) begin
      for (int i = 0; i < w; i++) begin
        if (use_gaps) begin
          r = lcg_next();
          repeat (r[31:30]) begin
            m_in_enable = 1'b0;
            @(negedge clk);
          end
        end
        m_in        = mem_vec[j*w + i];
        m_in_enable = 1'b1;
        tries = 0;
        #1;
        while (!m_out_enable && tries < TIMEOUT_CYCLES && !aborted) begin
          @(negedge clk);
          #1;
          tries++;
        end
        if (!m_out_enable) begin
          if (!aborted) report_timeout("memory request");
          m_in_enable = 1'b0;
          return;
        end
        if (i == w - 1) last_word_cycle[j] = cycle;
        @(negedge clk);
      end
    end
    m_in_enable = 1'b0;
  endtask

  task automatic collect_scores(input int n);
    int tries;
    for (int j = 0; j < n; j++) begin
      tries = 0;
      @(negedge clk);
      while (!c_out_enable && tries < TIMEOUT_CYCLES && !aborted) begin
        @(negedge clk);
        tries++;
      end
      if (!c_out_enable) begin
        if (!aborted) report_timeout("score pulse");
        return;
      end
      score_seen[j]  = c_out;
      score_cycle[j] = cycle;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  task automatic wait_done();
    logic [31:0] status;
    int          tries;
    tries = 0;
    axi_read(`NTM_REG_STATUS, status);
    while (!status[1] && tries < TIMEOUT_CYCLES && !aborted) begin
      axi_read(`NTM_REG_STATUS, status);
      tries++;
    end
    if (!status[1] && !aborted) report_timeout("done status");
  endtask

  // Streams one run and checks scores, latency, status and best row
  task automatic stream_and_check(input int n, input int w, input word_t b);
    int    first_pulses;
    int    best_index;
    word_t best_score;
    word_t expected;
    first_pulses = pulse_count;
    fork
      begin
        send_key(w);
        send_memory(n, w);
      end
      collect_scores(n);
    join
    best_index = 0;
    best_score = model_score(0, w, b);
    for (int j = 0; j < n; j++) begin
      expected = model_score(j, w, b);
      check_value(score_seen[j], expected, $sformatf("score of row %0d", j));
      check_value(32'(score_cycle[j] - last_word_cycle[j]), 32'd2,
                  $sformatf("score latency of row %0d", j));
      if (expected > best_score) begin
        best_score = expected;
        best_index = j;
      end
    end
    wait_done();
    check_value(32'(pulse_count - first_pulses), 32'(n), "number of score pulses");
    read_check(`NTM_REG_STATUS, 32'h2, "status after run");
    read_check(`NTM_REG_BEST_INDEX, 32'(best_index), "best index");
    read_check(`NTM_REG_BEST_SCORE, best_score, "best score");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_registers();
    read_check(`NTM_REG_CTRL, 32'd0, "ctrl after reset");
    read_check(`NTM_REG_STATUS, 32'd0, "status after reset");
    read_check(`NTM_REG_SIZE_N, 32'd0, "size_n after reset");
    read_check(`NTM_REG_SIZE_W, 32'd1, "size_w after reset");
    read_check(`NTM_REG_BETA, 32'd0, "beta after reset");
    read_check(`NTM_REG_BEST_INDEX, 32'd0, "best index after reset");
    read_check(`NTM_REG_BEST_SCORE, 32'd0, "best score after reset");
    axi_write(`NTM_REG_SIZE_N, 32'd1234);
    read_check(`NTM_REG_SIZE_N, 32'd1234, "size_n readback");
    axi_write(`NTM_REG_BETA, 32'hFFFE_8000);
    read_check(`NTM_REG_BETA, 32'hFFFE_8000, "beta readback");
    axi_write(`NTM_REG_SIZE_W, 32'd5);
    axi_write(`NTM_REG_SIZE_W, 32'd0);
    read_check(`NTM_REG_SIZE_W, 32'd5, "size_w keeps value after 0");
    axi_write(`NTM_REG_SIZE_W, 32'(`NTM_MAX_W + 1));
    read_check(`NTM_REG_SIZE_W, 32'd5, "size_w keeps value after max+1");
    // Unmapped offset ignores the write
    axi_write(8'h1C, 32'hDEAD_BEEF);
    read_check(8'h1C, 32'd0, "unmapped address");
  endtask

  // Scores of -20, -10, 0 and 10 in back to back rows
  task automatic test_basic();
    use_gaps = 1'b0;
    for (int i = 0; i < 4; i++) key_vec[i] = word_t'((i + 1) * 65536);
    for (int j = 0; j < 4; j++) begin
      for (int i = 0; i < 4; i++) mem_vec[j*4 + i] = word_t'((j - i) * 65536);
    end
    configure(4, 4, 32'h0001_0000);
    axi_write(`NTM_REG_CTRL, 32'd1);
    stream_and_check(4, 4, 32'h0001_0000);
  endtask

  task automatic test_random();
    word_t b;
    use_gaps = 1'b1;
    for (int i = 0; i < `NTM_MAX_W; i++) key_vec[i] = lcg_next();
    for (int k = 0; k < MAX_ROWS*`NTM_MAX_W; k++) mem_vec[k] = lcg_next();
    b = lcg_next();
    configure(MAX_ROWS, `NTM_MAX_W, b);
    axi_write(`NTM_REG_CTRL, 32'd1);
    stream_and_check(MAX_ROWS, `NTM_MAX_W, b);
  endtask

  // Rows 1 and 3 share the top score, row 1 must win
  task automatic test_tie();
    use_gaps = 1'b0;
    key_vec[0] = 32'h0001_0000;
    key_vec[1] = 32'h0001_0000;
    mem_vec[0] = 32'h0001_0000;
    mem_vec[1] = 32'h0000_0000;
    mem_vec[2] = 32'h0002_0000;
    mem_vec[3] = 32'h0001_0000;
    mem_vec[4] = 32'h0000_0000;
    mem_vec[5] = 32'h0000_0000;
    mem_vec[6] = 32'h0001_0000;
    mem_vec[7] = 32'h0002_0000;
    configure(4, 2, 32'h0002_0000);
    axi_write(`NTM_REG_CTRL, 32'd1);
    stream_and_check(4, 2, 32'h0002_0000);
  endtask

  task automatic test_start_rules();
    bit seen;
    axi_write(`NTM_REG_SIZE_N, 32'd0);
    axi_write(`NTM_REG_CTRL, 32'd1);
    seen = 1'b0;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      if (k_out_enable) seen = 1'b1;
    end
    check_value(32'(seen), 32'd0, "key request after refused start");
    // Busy clear, done still held from the last run
    read_check(`NTM_REG_STATUS, 32'h2, "status after refused start");
    use_gaps = 1'b1;
    for (int i = 0; i < 4; i++) key_vec[i] = word_t'((i - 1) * 65536);
    for (int j = 0; j < 3; j++) begin
      for (int i = 0; i < 4; i++) mem_vec[j*4 + i] = word_t'((j * i - 2) * 32768);
    end
    configure(3, 4, 32'h0000_C000);
    axi_write(`NTM_REG_CTRL, 32'd1);
    read_check(`NTM_REG_STATUS, 32'h1, "status after accepted start");
    // Second start while busy
    axi_write(`NTM_REG_CTRL, 32'd1);
    stream_and_check(3, 4, 32'h0000_C000);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = 4'hF;
    s_axi_bready  = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_rready  = 1'b0;
    k_in_enable   = 1'b0;
    k_in          = '0;
    m_in_enable   = 1'b0;
    m_in          = '0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    aborted       = 1'b0;
    use_gaps      = 1'b0;
    lcg_state     = 32'h2b55;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_registers();
    if (!aborted) test_basic();
    if (!aborted) test_random();
    if (!aborted) test_tie();
    if (!aborted) test_start_rules();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeout_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+source
source/ntm_pkg.sv
source/ntm_key_buffer.sv
source/ntm_dot_product.sv
source/ntm_config_regs.sv
source/ntm_content_addressing.sv
source/ntm_read_content_weighting.sv
bench/ntm_read_content_weighting_tb.sv

/* Makefile */
# Verilator build and run for the content weighting engine
VERILATOR    ?= verilator
TOP          ?= ntm_read_content_weighting_tb
FILELIST     ?= sources.f
BUILD_DIR    ?= obj_dir
LOG          ?= sim.log
FAIL_PATTERN ?= Test failed
PASS_PATTERN ?= Test passed
VFLAGS       ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_PATTERN)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
